/* hw/core_pkg.sv */
// Core type package

package core_pkg;

  ////////////////////////////////////////
  // Operations
  ////////////////////////////////////////

  // One code per R form and per I form
  typedef enum logic [3:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_SLT,
    OP_ADDI,
    OP_ANDI,
    OP_ORI,
    OP_XORI,
    OP_SLTI
  } alu_op_e;

  ////////////////////////////////////////
  // Opcodes and function fields
  ////////////////////////////////////////

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

  // Shared by the R and I forms
  localparam logic [2:0] FUNCT3_ADD = 3'b000;
  localparam logic [2:0] FUNCT3_SLT = 3'b010;
  localparam logic [2:0] FUNCT3_XOR = 3'b100;
  localparam logic [2:0] FUNCT3_OR  = 3'b110;
  localparam logic [2:0] FUNCT3_AND = 3'b111;

  // Selects SUB over ADD
  localparam logic [6:0] FUNCT7_SUB = 7'b0100000;

  ////////////////////////////////////////
  // Instruction views
  ////////////////////////////////////////

  // Register-register format
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_instr_t;

  // Register-immediate format
  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_instr_t;

  // Same word seen both ways, the opcode decides which view applies
  typedef union packed {
    r_instr_t r;
    i_instr_t i;
  } instr_u;

endpackage

/* hw/dec_if.sv */
// Decoded instruction bundle

`timescale 1ns/1ps

interface dec_if
  import core_pkg::*;
#(
  parameter int unsigned DataWidth = 32
) ();

  // High for one cycle per legal instruction
  logic                 valid;
  alu_op_e              op;
  // Register indices
  logic [4:0]           rs1;
  logic [4:0]           rs2;
  logic [4:0]           rd;
  // Sign-extended immediate
  logic [DataWidth-1:0] imm;
  // Second operand comes from imm
  logic                 use_imm;

  // Decoder side
  modport dec_mp (output valid, op, rs1, rs2, rd, imm, use_imm);

  // Execute side
  modport exe_mp (input valid, op, rs1, rs2, rd, imm, use_imm);

endinterface

/* hw/rf_if.sv */
// Register file access ports

`timescale 1ns/1ps

interface rf_if #(
  parameter int unsigned DataWidth = 32
) ();

  ////////////////////////////////////////
  // Read ports
  ////////////////////////////////////////

  logic [4:0]           raddr_a;
  logic [DataWidth-1:0] rdata_a;
  logic [4:0]           raddr_b;
  logic [DataWidth-1:0] rdata_b;

  ////////////////////////////////////////
  // Write port
  ////////////////////////////////////////

  logic [4:0]           waddr;
  logic [DataWidth-1:0] wdata;
  // Sampled at the rising edge
  logic                 we;

  // Register file side
  modport rf_mp (
    input  raddr_a, raddr_b, waddr, wdata, we,
    output rdata_a, rdata_b
  );

  // Execute side
  modport exe_mp (
    output raddr_a, raddr_b, waddr, wdata, we,
    input  rdata_a, rdata_b
  );

endinterface

/* hw/clock_gate.sv */
// Latch-based clock gate

`timescale 1ns/1ps

module clock_gate (
  input  logic clk_i,
  input  logic en_i,
  output logic clk_o
);

  logic en_latched;

  // Enable may only change while the clock is low
  always_latch begin : en_latch
    if (!clk_i) begin
      en_latched = en_i;
    end
  end

  // No glitch, since en_latched is stable during the high phase
  assign clk_o = clk_i & en_latched;

endmodule

/* hw/instr_decoder.sv */
// Instruction decoder

`timescale 1ns/1ps

module instr_decoder
  import core_pkg::*;
#(
  parameter bit RV32E = 1'b0
) (
  input  logic   clk_int,
  input  logic   rst_ni,
  input  logic   instr_valid_i,
  input  instr_u instr_i,
  output logic   illegal_o,
  dec_if.dec_mp  dec_o
);

  alu_op_e op_d;
  logic    use_imm_d;
  logic    legal_d;
  logic    reg_range_ok;

  ////////////////////////////////////////
  // Register index check
  ////////////////////////////////////////

  // RV32E only has x0 to x15
  always_comb begin : reg_check
    reg_range_ok = 1'b1;
    if (RV32E) begin
      if (instr_i.r.rd[4] || instr_i.r.rs1[4]) begin
        reg_range_ok = 1'b0;
      end
      // rs2 only exists in the R view
      if ((instr_i.r.opcode == OPC_OP) && instr_i.r.rs2[4]) begin
        reg_range_ok = 1'b0;
      end
    end
  end

  ////////////////////////////////////////
  // Operation decode
  ////////////////////////////////////////

  always_comb begin : op_decode
    op_d      = OP_ADD;
    use_imm_d = 1'b0;
    legal_d   = 1'b0;
    case (instr_i.r.opcode)
      OPC_OP: begin
        // Only SUB may carry a nonzero funct7
        legal_d = (instr_i.r.funct7 == '0);
        case (instr_i.r.funct3)
          FUNCT3_ADD: begin
            if (instr_i.r.funct7 == FUNCT7_SUB) begin
              op_d    = OP_SUB;
              legal_d = 1'b1;
            end
          end
          FUNCT3_SLT: op_d = OP_SLT;
          FUNCT3_XOR: op_d = OP_XOR;
          FUNCT3_OR:  op_d = OP_OR;
          FUNCT3_AND: op_d = OP_AND;
          default:    legal_d = 1'b0;
        endcase
      end
      OPC_OP_IMM: begin
        use_imm_d = 1'b1;
        legal_d   = 1'b1;
        case (instr_i.i.funct3)
          FUNCT3_ADD: op_d = OP_ADDI;
          FUNCT3_SLT: op_d = OP_SLTI;
          FUNCT3_XOR: op_d = OP_XORI;
          FUNCT3_OR:  op_d = OP_ORI;
          FUNCT3_AND: op_d = OP_ANDI;
          default:    legal_d = 1'b0;
        endcase
      end
      default: legal_d = 1'b0;
    endcase
    legal_d = legal_d & reg_range_ok;
  end

  ////////////////////////////////////////
  // Output registers
  ////////////////////////////////////////

  // Exactly one of the two strobes per accepted word
  always_ff @(posedge clk_int or negedge rst_ni) begin : strobe_regs
    if (!rst_ni) begin
      dec_o.valid <= 1'b0;
      illegal_o   <= 1'b0;
    end else begin
      dec_o.valid <= instr_valid_i & legal_d;
      illegal_o   <= instr_valid_i & ~legal_d;
    end
  end

  // Bundle fields only move with a new word
  always_ff @(posedge clk_int) begin : bundle_regs
    if (instr_valid_i) begin
      dec_o.op      <= op_d;
      dec_o.use_imm <= use_imm_d;
      dec_o.rs1     <= instr_i.r.rs1;
      dec_o.rs2     <= instr_i.r.rs2;
      dec_o.rd      <= instr_i.r.rd;
      // Signed source widens with sign bits
      dec_o.imm     <= $signed(instr_i.i.imm12);
    end
  end

endmodule

/* hw/latch_regfile.sv */
// Latch-based register file

`timescale 1ns/1ps

module latch_regfile #(
  parameter bit          RV32E     = 1'b0,
  parameter int unsigned DataWidth = 32
) (
  input  logic clk_int,
  input  logic rst_ni,
  rf_if.rf_mp  rf_i
);

  localparam int unsigned AddrWidth = RV32E ? 4 : 5;
  localparam int unsigned NumWords  = 2 ** AddrWidth;

  logic [DataWidth-1:0] mem [NumWords];
  logic [DataWidth-1:0] wdata_q;
  logic [AddrWidth-1:0] raddr_a_int;
  logic [AddrWidth-1:0] raddr_b_int;
  logic [AddrWidth-1:0] waddr_int;
  logic [NumWords-1:1]  waddr_onehot;
  logic [NumWords-1:1]  word_clk;
  logic                 clk_we;

  // Upper index bit dropped under RV32E
  assign raddr_a_int = rf_i.raddr_a[AddrWidth-1:0];
  assign raddr_b_int = rf_i.raddr_b[AddrWidth-1:0];
  assign waddr_int   = rf_i.waddr[AddrWidth-1:0];

  ////////////////////////////////////////
  // Read
  ////////////////////////////////////////

  // Plain muxes with no clock involved
  assign rf_i.rdata_a = mem[raddr_a_int];
  assign rf_i.rdata_b = mem[raddr_b_int];

  ////////////////////////////////////////
  // Write data capture
  ////////////////////////////////////////

  // Global gate runs only in write cycles
  clock_gate u_cg_we (
    .clk_i (clk_int),
    .en_i  (rf_i.we),
    .clk_o (clk_we)
  );

  always_ff @(posedge clk_we or negedge rst_ni) begin : wdata_reg
    if (!rst_ni) begin
      wdata_q <= '0;
    end else begin
      wdata_q <= rf_i.wdata;
    end
  end

  ////////////////////////////////////////
  // Write address decode
  ////////////////////////////////////////

  // One-hot select without an entry for word 0
  always_comb begin : waddr_decode
    for (int unsigned w = 1; w < NumWords; w++) begin
      waddr_onehot[w] = rf_i.we && (waddr_int == AddrWidth'(w));
    end
  end

  ////////////////////////////////////////
  // Word storage
  ////////////////////////////////////////

  // Register 0 is hardwired
  assign mem[0] = '0;

  for (genvar w = 1; w < NumWords; w++) begin : gen_word
    // Word clock pulses high for the written word only
    clock_gate u_cg_word (
      .clk_i (clk_we),
      .en_i  (waddr_onehot[w]),
      .clk_o (word_clk[w])
    );

    // Transparent while the word clock is high
    always_latch begin : word_latch
      if (word_clk[w]) begin
        mem[w] = wdata_q;
      end
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // Decoder must have filtered indices out of range
  waddr_range_a: assert property (
    @(posedge clk_int) disable iff (!rst_ni)
    rf_i.we |-> (rf_i.waddr < NumWords)
  );

endmodule

/* hw/exec_unit.sv */
// Execute unit

`timescale 1ns/1ps

module exec_unit
  import core_pkg::*;
#(
  parameter int unsigned DataWidth = 32
) (
  input  logic                 clk_int,
  input  logic                 rst_ni,
  dec_if.exe_mp                dec_i,
  rf_if.exe_mp                 rf_o,
  output logic [DataWidth-1:0] result_o,
  output logic                 result_valid_o
);

  logic [DataWidth-1:0] operand_a;
  logic [DataWidth-1:0] operand_b;
  logic [DataWidth-1:0] alu_result;
  logic                 less_than;

  ////////////////////////////////////////
  // Operand fetch
  ////////////////////////////////////////

  assign rf_o.raddr_a = dec_i.rs1;
  assign rf_o.raddr_b = dec_i.rs2;

  assign operand_a = rf_o.rdata_a;
  // Immediate replaces rs2 for the I forms
  assign operand_b = dec_i.use_imm ? dec_i.imm : rf_o.rdata_b;

  ////////////////////////////////////////
  // ALU
  ////////////////////////////////////////

  assign less_than = $signed(operand_a) < $signed(operand_b);

  always_comb begin : alu
    case (dec_i.op)
      OP_ADD, OP_ADDI: alu_result = operand_a + operand_b;
      OP_SUB:          alu_result = operand_a - operand_b;
      OP_AND, OP_ANDI: alu_result = operand_a & operand_b;
      OP_OR, OP_ORI:   alu_result = operand_a | operand_b;
      OP_XOR, OP_XORI: alu_result = operand_a ^ operand_b;
      OP_SLT, OP_SLTI: alu_result = {{(DataWidth - 1){1'b0}}, less_than};
      default:         alu_result = '0;
    endcase
  end

  ////////////////////////////////////////
  // Write back
  ////////////////////////////////////////

  // Skip x0 since the register file would drop it anyway
  assign rf_o.we    = dec_i.valid && (dec_i.rd != '0);
  assign rf_o.waddr = dec_i.rd;
  assign rf_o.wdata = alu_result;

  // Result leaves at the same edge as the write
  always_ff @(posedge clk_int or negedge rst_ni) begin : result_regs
    if (!rst_ni) begin
      result_o       <= '0;
      result_valid_o <= 1'b0;
    end else begin
      result_valid_o <= dec_i.valid;
      if (dec_i.valid) begin
        result_o <= alu_result;
      end
    end
  end

endmodule

/* hw/mini_core_top.sv */
// Execute slice top level

`timescale 1ns/1ps

module mini_core_top #(
  parameter bit          RV32E     = 1'b0,
  parameter int unsigned DataWidth = 32
) (
  input  logic                 clk_int,
  input  logic                 rst_ni,
  // Instruction stream
  input  logic                 instr_valid_i,
  input  logic [31:0]          instr_i,
  // Results
  output logic [DataWidth-1:0] result_o,
  output logic                 result_valid_o,
  output logic                 illegal_o
);

  ////////////////////////////////////////
  // Internal buses
  ////////////////////////////////////////

  dec_if #(.DataWidth(DataWidth)) dec_bus ();
  rf_if  #(.DataWidth(DataWidth)) rf_bus ();

  ////////////////////////////////////////
  // Decode
  ////////////////////////////////////////

  // Raw word reinterpreted as the instruction union
  instr_decoder #(
    .RV32E (RV32E)
  ) u_decoder (
    .clk_int       (clk_int),
    .rst_ni        (rst_ni),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .illegal_o     (illegal_o),
    .dec_o         (dec_bus.dec_mp)
  );

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////

  latch_regfile #(
    .RV32E     (RV32E),
    .DataWidth (DataWidth)
  ) u_regfile (
    .clk_int (clk_int),
    .rst_ni  (rst_ni),
    .rf_i    (rf_bus.rf_mp)
  );

  ////////////////////////////////////////
  // Execute
  ////////////////////////////////////////

  exec_unit #(
    .DataWidth (DataWidth)
  ) u_exec (
    .clk_int        (clk_int),
    .rst_ni         (rst_ni),
    .dec_i          (dec_bus.exe_mp),
    .rf_o           (rf_bus.exe_mp),
    .result_o       (result_o),
    .result_valid_o (result_valid_o)
  );

endmodule

/* dv/result_checker.sv */
// Result checker

`timescale 1ns/1ps

module result_checker #(
  parameter int unsigned DataWidth = 32
) (
  input  logic                 clk_int,
  input  logic                 rst_ni,
  input  logic [DataWidth-1:0] result_i,
  input  logic                 result_valid_i,
  input  logic                 illegal_i,
  output int                   done_count_o,
  output int                   error_count_o
);

  // Pending expectations, oldest first
  string                name_q[$];
  bit                   illegal_q[$];
  logic [DataWidth-1:0] value_q[$];

  int done_count;
  int error_count;
  bit seen_strobe;
  bit reset_value_bad;

  assign done_count_o  = done_count;
  assign error_count_o = error_count;

  // Called by the testbench for every instruction it drives
  task push_expect(input string name, input bit illegal, input logic [DataWidth-1:0] value);
    name_q.push_back(name);
    illegal_q.push_back(illegal);
    value_q.push_back(value);
  endtask

  ////////////////////////////////////////
  // Matching one strobe
  ////////////////////////////////////////

  task check_one(input bit got_illegal);
    string                name;
    bit                   exp_illegal;
    logic [DataWidth-1:0] exp_value;
    if (name_q.size() == 0) begin
      $display("ERROR: %s strobe seen with no instruction pending",
               got_illegal ? "illegal_o" : "result_valid_o");
      error_count++;
    end else begin
      name        = name_q.pop_front();
      exp_illegal = illegal_q.pop_front();
      exp_value   = value_q.pop_front();
      if (got_illegal != exp_illegal) begin
        $display("[FAIL] %s expected illegal=%0b actual illegal=%0b",
                 name, exp_illegal, got_illegal);
        error_count++;
      end else if (!got_illegal && (result_i !== exp_value)) begin
        $display("[FAIL] %s expected 0x%08h actual 0x%08h", name, exp_value, result_i);
        error_count++;
      end else if (got_illegal) begin
        $display("[PASS] %s flagged illegal", name);
      end else begin
        $display("[PASS] %s result 0x%08h", name, result_i);
      end
      done_count++;
    end
  endtask

  ////////////////////////////////////////
  // Sampling
  ////////////////////////////////////////

  // Outputs settle after the rising edge, so look at the falling one
  always @(negedge clk_int) begin : compare
    if (!rst_ni) begin
      seen_strobe = 1'b0;
    end else begin
      // A result always belongs to an older word than a same-cycle illegal flag
      if (result_valid_i) begin
        check_one(1'b0);
      end
      if (illegal_i) begin
        check_one(1'b1);
      end
      if (result_valid_i || illegal_i) begin
        seen_strobe = 1'b1;
      end else if (!seen_strobe && (result_i !== '0) && !reset_value_bad) begin
        $display("ERROR: result_o is not zero after reset");
        reset_value_bad = 1'b1;
        error_count++;
      end
    end
  end

  initial begin : init_counts
    done_count      = 0;
    error_count     = 0;
    seen_strobe     = 1'b0;
    reset_value_bad = 1'b0;
  end

endmodule

/* dv/tb_mini_core.sv */
// Execute slice testbench

`timescale 1ns/1ps

module tb_mini_core;

  localparam int unsigned NumTests       = 23;
  localparam int unsigned WatchdogCycles = NumTests * 4 + 20;

  // Encodings used to build the stimulus words
  localparam logic [6:0] OpcReg = 7'b0110011;
  localparam logic [6:0] OpcImm = 7'b0010011;
  localparam logic [6:0] OpcBad = 7'b1111111;
  localparam logic [2:0] F3Add  = 3'b000;
  localparam logic [2:0] F3Slt  = 3'b010;
  localparam logic [2:0] F3Xor  = 3'b100;
  localparam logic [2:0] F3Or   = 3'b110;
  localparam logic [2:0] F3And  = 3'b111;
  localparam logic [2:0] F3Sll  = 3'b001;
  localparam logic [6:0] F7Sub  = 7'b0100000;

  logic        clk_int;
  logic        rst_ni;
  logic        instr_valid_i;
  logic [31:0] instr_i;
  logic [31:0] result_o;
  logic        result_valid_o;
  logic        illegal_o;
  int          done_count;
  int          error_count;

  // Stimulus and expected values
  string       test_name   [NumTests];
  logic [31:0] test_word   [NumTests];
  bit          test_illegal[NumTests];
  logic [31:0] test_expect [NumTests];
  int          num_entries;

  mini_core_top uut (
    .clk_int        (clk_int),
    .rst_ni         (rst_ni),
    .instr_valid_i  (instr_valid_i),
    .instr_i        (instr_i),
    .result_o       (result_o),
    .result_valid_o (result_valid_o),
    .illegal_o      (illegal_o)
  );

  result_checker u_checker (
    .clk_int        (clk_int),
    .rst_ni         (rst_ni),
    .result_i       (result_o),
    .result_valid_i (result_valid_o),
    .illegal_i      (illegal_o),
    .done_count_o   (done_count),
    .error_count_o  (error_count)
  );

  ////////////////////////////////////////
  // Word encoding
  ////////////////////////////////////////

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OpcReg};
  endfunction

  function automatic logic [31:0] enc_i(input logic [6:0] opc, input logic [11:0] imm,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {imm, rs1, f3, rd, opc};
  endfunction

  task add_entry(input string name, input logic [31:0] word, input bit illegal,
                 input logic [31:0] expect_value);
    test_name[num_entries]    = name;
    test_word[num_entries]    = word;
    test_illegal[num_entries] = illegal;
    test_expect[num_entries]  = expect_value;
    num_entries++;
  endtask

  ////////////////////////////////////////
  // Test table
  ////////////////////////////////////////

  task build_table();
    num_entries = 0;
    // Constants through x0, negative ones sign-extend
    add_entry("addi_x1_100",      enc_i(OpcImm, 12'd100, 5'd0, F3Add, 5'd1), 0, 32'h0000_0064);
    add_entry("addi_x2_m7",       enc_i(OpcImm, 12'hFF9, 5'd0, F3Add, 5'd2), 0, 32'hFFFF_FFF9);
    add_entry("addi_x3_0f0",      enc_i(OpcImm, 12'h0F0, 5'd0, F3Add, 5'd3), 0, 32'h0000_00F0);
    add_entry("addi_x4_7ff",      enc_i(OpcImm, 12'h7FF, 5'd0, F3Add, 5'd4), 0, 32'h0000_07FF);
    add_entry("addi_x5_m2048",    enc_i(OpcImm, 12'h800, 5'd0, F3Add, 5'd5), 0, 32'hFFFF_F800);
    // Register forms, the SUB reads x6 right after it is written
    add_entry("add_x6_x1_x2",     enc_r(7'd0,  5'd2, 5'd1, F3Add, 5'd6),  0, 32'h0000_005D);
    add_entry("sub_x7_x6_x1",     enc_r(F7Sub, 5'd1, 5'd6, F3Add, 5'd7),  0, 32'hFFFF_FFF9);
    add_entry("and_x8_x3_x4",     enc_r(7'd0,  5'd4, 5'd3, F3And, 5'd8),  0, 32'h0000_00F0);
    add_entry("or_x9_x3_x5",      enc_r(7'd0,  5'd5, 5'd3, F3Or,  5'd9),  0, 32'hFFFF_F8F0);
    add_entry("xor_x10_x4_x5",    enc_r(7'd0,  5'd5, 5'd4, F3Xor, 5'd10), 0, 32'hFFFF_FFFF);
    add_entry("slt_x11_x2_x1",    enc_r(7'd0,  5'd1, 5'd2, F3Slt, 5'd11), 0, 32'h0000_0001);
    add_entry("slt_x12_x1_x2",    enc_r(7'd0,  5'd2, 5'd1, F3Slt, 5'd12), 0, 32'h0000_0000);
    // Immediate forms
    add_entry("andi_x13_x4_0ff",  enc_i(OpcImm, 12'h0FF, 5'd4, F3And, 5'd13), 0, 32'h0000_00FF);
    add_entry("ori_x14_x3_00f",   enc_i(OpcImm, 12'h00F, 5'd3, F3Or,  5'd14), 0, 32'h0000_00FF);
    add_entry("xori_x15_x1_m1",   enc_i(OpcImm, 12'hFFF, 5'd1, F3Xor, 5'd15), 0, 32'hFFFF_FF9B);
    add_entry("slti_x16_x2_0",    enc_i(OpcImm, 12'd0,   5'd2, F3Slt, 5'd16), 0, 32'h0000_0001);
    add_entry("slti_x17_x1_50",   enc_i(OpcImm, 12'd50,  5'd1, F3Slt, 5'd17), 0, 32'h0000_0000);
    // Write to x0 is presented but dropped
    add_entry("addi_x0_55",       enc_i(OpcImm, 12'd55, 5'd0, F3Add, 5'd0), 0, 32'h0000_0037);
    add_entry("add_x6_x0_x0",     enc_r(7'd0, 5'd0, 5'd0, F3Add, 5'd6),    0, 32'h0000_0000);
    // Illegal words aimed at x1, which must keep 100
    add_entry("bad_opcode_x1",    enc_i(OpcBad, 12'd5, 5'd3, F3Add, 5'd1), 1, 32'h0000_0000);
    add_entry("bad_funct7_x1",    enc_r(7'b0000001, 5'd4, 5'd3, F3Add, 5'd1), 1, 32'h0000_0000);
    add_entry("bad_funct3_x1",    enc_i(OpcImm, 12'd1, 5'd3, F3Sll, 5'd1), 1, 32'h0000_0000);
    add_entry("add_x19_x1_x0",    enc_r(7'd0, 5'd0, 5'd1, F3Add, 5'd19),  0, 32'h0000_0064);
  endtask

  ////////////////////////////////////////
  // Clock and watchdog
  ////////////////////////////////////////

  initial begin : clock_gen
    clk_int = 1'b0;
    forever #10 clk_int = ~clk_int;
  end

  initial begin : watchdog
    repeat (WatchdogCycles) @(posedge clk_int);
    $display("Timeout: %0d of %0d tests finished within %0d cycles",
             done_count, NumTests, WatchdogCycles);
    $display("Testbench failed");
    $finish;
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial begin : stimulus
    rst_ni        = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    build_table();
    repeat (3) @(posedge clk_int);
    @(negedge clk_int);
    rst_ni = 1'b1;
    // Quiet window, the checker flags any strobe here
    repeat (3) @(negedge clk_int);
    // One word per cycle, back to back
    for (int t = 0; t < num_entries; t++) begin
      instr_valid_i = 1'b1;
      instr_i       = test_word[t];
      u_checker.push_expect(test_name[t], test_illegal[t], test_expect[t]);
      @(negedge clk_int);
    end
    instr_valid_i = 1'b0;
    instr_i       = '0;
    wait (done_count == NumTests);
    // Drain, catches stray strobes
    repeat (4) @(negedge clk_int);
    $display("Summary: %0d of %0d tests finished, %0d errors", done_count, NumTests, error_count);
    if ((error_count == 0) && (done_count == NumTests)) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* src.f */
hw/core_pkg.sv
hw/dec_if.sv
hw/rf_if.sv
hw/clock_gate.sv
hw/instr_decoder.sv
hw/latch_regfile.sv
hw/exec_unit.sv
hw/mini_core_top.sv
dv/result_checker.sv
dv/tb_mini_core.sv

/* Bender.yml */
package:
  name: mini_core

sources:
  - files:
      - hw/core_pkg.sv
      - hw/dec_if.sv
      - hw/rf_if.sv
      - hw/clock_gate.sv
      - hw/instr_decoder.sv
      - hw/latch_regfile.sv
      - hw/exec_unit.sv
      - hw/mini_core_top.sv
  - target: test
    files:
      - dv/result_checker.sv
      - dv/tb_mini_core.sv
